// ==== Bender.yml ====
package:
  name: dz_rx

sources:
  - include_dirs:
      - src
    files:
      - src/dzPkg.sv
      - src/dzUartRx.sv
      - src/dzScanner.sv
      - src/dzRbuf.sv
      - src/dzRegs.sv
      - src/dzTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/dzTb.sv

// ==== src/dzPkg.sv ====
package dzPkg;

   // RBUF view of the offset-2 word
   typedef struct packed {
      logic       dval;
      logic       ovre;
      logic       frme;
      logic       pare;
      logic       zero;
      logic [2:0] line;
      logic [7:0] data;
   } rbufFields;

   // LPR view of the offset-2 word
   // Speed, stop and charLen are carried but not decoded
   typedef struct packed {
      logic [2:0] unused;
      logic       rxOn;
      logic [3:0] speed;
      logic       parOdd;
      logic       parEn;
      logic       stop;
      logic [1:0] charLen;
      logic [2:0] line;
   } lprFields;

   // Offset 2 reads as RBUF and writes as LPR
   typedef union packed {
      rbufFields rbuf;
      lprFields  lpr;
   } dzWord;

   // One silo word, RBUF without dval
   typedef struct packed {
      logic       ovre;
      logic       frme;
      logic       pare;
      logic       zero;
      logic [2:0] line;
      logic [7:0] data;
   } siloEntry;

endpackage

// ==== src/dzRbuf.sv ====
`timescale 1ns/1ps
`include "dz_settings.svh"

module dzRbuf (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clr,
   input  logic                 mse,
   input  logic                 sae,
   input  logic [2:0]           scan,
   input  logic                 busFull,
   input  logic [7:0]           busData,
   input  logic                 busFrme,
   input  logic                 busPare,
   input  logic                 rbufRead,
   output logic [`DZ_LINES-1:0] lineClr,
   output logic                 rdone,
   output logic                 siloAlarm,
   output dzPkg::dzWord         rbufWord
);

   localparam int PtrW = $clog2(`DZ_SILO_SIZE);
   localparam int AlarmW = $clog2(`DZ_ALARM_COUNT + 1);
   localparam logic [PtrW-1:0] LastSlot = PtrW'(`DZ_SILO_SIZE - 1);
   localparam logic [AlarmW-1:0] AlarmHit = AlarmW'(`DZ_ALARM_COUNT);

   dzPkg::siloEntry mem [`DZ_SILO_SIZE];
   dzPkg::siloEntry fifoData;
   dzPkg::siloEntry wrEntry;

   logic [PtrW-1:0]   depth;
   logic [PtrW-1:0]   depthNext;
   logic [PtrW-1:0]   rdPtr;
   logic [PtrW-1:0]   wrPtr;
   logic [PtrW-1:0]   lastPtr;
   logic [PtrW-1:0]   wrAddr;
   logic [AlarmW-1:0] alarmCnt;
   logic              wr;
   logic              rd;
   logic              pop;
   logic              push;
   logic              rbufReadDly;
   logic              wrDly;
   logic              rdDly;
   logic              siloEmpty;
   logic              siloFull;
   logic              ovre;
   logic              dval;

   //////////////////////////////
   // Receive bus side
   //////////////////////////////

   // Store whenever the granted line holds a character
   assign wr = busFull & mse;

   // Release the granted receiver as its character goes in
   always_comb
   begin
      lineClr = '0;
      if (wr)
         lineClr[scan] = 1'b1;
   end

   // Pop after the host read has finished
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rbufReadDly <= 1'b0;
      else
         rbufReadDly <= rbufRead;
   end

   assign rd = rbufReadDly & ~rbufRead;

   // Delayed strobes for the status flags
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrDly <= 1'b0;
         rdDly <= 1'b0;
      end
      else
      begin
         wrDly <= wr;
         rdDly <= rd;
      end
   end

   //////////////////////////////
   // Silo pointers and depth
   //////////////////////////////

   assign siloEmpty = (depth == '0);
   assign siloFull  = (depth == LastSlot);
   assign rdone     = ~siloEmpty;

   assign pop  = rd & ~siloEmpty;
   // A pop in the same cycle frees a slot for the write
   assign push = wr & (~siloFull | pop);

   always_comb
   begin
      depthNext = depth;
      if (push & ~pop)
         depthNext = depth + 1'b1;
      else if (pop & ~push)
         depthNext = depth - 1'b1;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else if (clr)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else
      begin
         depth <= depthNext;
         if (pop)
            rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
         if (push)
            wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
      end
   end

   // Newest stored entry
   assign lastPtr = (wrPtr == '0) ? LastSlot : wrPtr - 1'b1;

   // Full silo replaces its newest entry
   assign wrAddr = push ? wrPtr : lastPtr;

   //////////////////////////////
   // Status flags
   //////////////////////////////

   // Follows full on a write, and again once a pop has settled
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ovre <= 1'b0;
      else if (clr)
         ovre <= 1'b0;
      else if (wr | rdDly)
         ovre <= siloFull;
   end

   // Valid once the head word has been fetched
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dval <= 1'b0;
      else if (clr)
         dval <= 1'b0;
      else if (rd | wrDly)
         dval <= (depthNext != '0);
   end

   // Alarm counter
   // Counts stores since the last read, not the depth
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         alarmCnt <= '0;
      else if (clr | rd | ~sae)
         alarmCnt <= '0;
      else if (wr && (alarmCnt != AlarmHit))
         alarmCnt <= alarmCnt + 1'b1;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         siloAlarm <= 1'b0;
      else if (clr | rd | ~sae)
         siloAlarm <= 1'b0;
      else if (alarmCnt == AlarmHit)
         siloAlarm <= 1'b1;
   end

   //////////////////////////////
   // Storage
   //////////////////////////////

   // Overrun marks the entry that took the place of lost characters
   always_comb
   begin
      wrEntry.ovre = siloFull | ovre;
      wrEntry.frme = busFrme;
      wrEntry.pare = busPare;
      wrEntry.zero = 1'b0;
      wrEntry.line = scan;
      wrEntry.data = busData;
   end

   always_ff @(posedge clk)
   begin
      if (wr)
         mem[wrAddr] <= wrEntry;
      fifoData <= mem[rdPtr];
   end

   // Head entry with dval on top
   always_comb
   begin
      rbufWord.rbuf.dval = dval;
      rbufWord.rbuf.ovre = fifoData.ovre;
      rbufWord.rbuf.frme = fifoData.frme;
      rbufWord.rbuf.pare = fifoData.pare;
      rbufWord.rbuf.zero = fifoData.zero;
      rbufWord.rbuf.line = fifoData.line;
      rbufWord.rbuf.data = fifoData.data;
   end

   depthCheck: assert property (@(posedge clk) disable iff (rst)
      depth <= LastSlot);

   // At most one receiver released per cycle
   lineClrCheck: assert property (@(posedge clk) disable iff (rst)
      $onehot0(lineClr));

endmodule

// ==== src/dzRegs.sv ====
`timescale 1ns/1ps
`include "dz_settings.svh"

module dzRegs (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [1:0]           addr,
   input  logic                 wrStb,
   input  dzPkg::dzWord         wrData,
   input  logic                 rdStb,
   input  logic                 rdone,
   input  logic                 siloAlarm,
   input  dzPkg::dzWord         rbufWord,
   output logic [15:0]          rdData,
   output logic                 mse,
   output logic                 sae,
   output logic                 clr,
   output logic                 rbufRead,
   output logic [`DZ_LINES-1:0] lineRxOn,
   output logic [`DZ_LINES-1:0] lineParEn,
   output logic [`DZ_LINES-1:0] lineParOdd
);

   logic csrWr;
   logic lprWr;

   assign csrWr = wrStb & (addr == `DZ_ADDR_CSR);
   assign lprWr = wrStb & (addr == `DZ_ADDR_RBUF);

   //////////////////////////////
   // CSR
   //////////////////////////////

   // Clear is a one cycle pulse, enables hold
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         clr <= 1'b0;
         mse <= 1'b0;
         sae <= 1'b0;
      end
      else
      begin
         clr <= csrWr & wrData[4];
         if (csrWr)
         begin
            mse <= wrData[5];
            sae <= wrData[12];
         end
      end
   end

   //////////////////////////////
   // LPR
   //////////////////////////////

   // Loads the settings of the addressed line only
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lineRxOn   <= '0;
         lineParEn  <= '0;
         lineParOdd <= '0;
      end
      else if (lprWr)
      begin
         lineRxOn[wrData.lpr.line]   <= wrData.lpr.rxOn;
         lineParEn[wrData.lpr.line]  <= wrData.lpr.parEn;
         lineParOdd[wrData.lpr.line] <= wrData.lpr.parOdd;
      end
   end

   //////////////////////////////
   // Read side
   //////////////////////////////

   // Held for the whole read, silo pops when it drops
   assign rbufRead = rdStb & (addr == `DZ_ADDR_RBUF);

   always_comb
   begin
      rdData = '0;
      if (rdStb)
      begin
         case (addr)
            `DZ_ADDR_CSR:
               rdData = {2'b00, siloAlarm, sae, 4'b0000,
                         rdone, 1'b0, mse, clr, 4'b0000};
            `DZ_ADDR_RBUF:
               rdData = rbufWord.rbuf;
            default:
               rdData = '0;
         endcase
      end
   end

   // Host never reads and writes in one cycle
   busCheck: assert property (@(posedge clk) disable iff (rst)
      !(wrStb && rdStb));

endmodule

// ==== src/dzScanner.sv ====
`timescale 1ns/1ps
`include "dz_settings.svh"

module dzScanner (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [`DZ_LINES-1:0]          full,
   input  logic [`DZ_LINES-1:0][7:0]     data,
   input  logic [`DZ_LINES-1:0]          frme,
   input  logic [`DZ_LINES-1:0]          pare,
   output logic [2:0]                    scan,
   output logic                          busFull,
   output logic [7:0]                    busData,
   output logic                          busFrme,
   output logic                          busPare
);

   //////////////////////////////
   // Scan counter
   //////////////////////////////

   // Round robin grant, one line per clock
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         scan <= '0;
      else
         scan <= scan + 1'b1;
   end

   //////////////////////////////
   // Receive bus multiplexer
   //////////////////////////////

   // Granted line drives the shared bus
   always_comb
   begin
      busFull = full[scan];
      busData = data[scan];
      busFrme = frme[scan];
      busPare = pare[scan];
   end

endmodule

// ==== src/dzTop.sv ====
`timescale 1ns/1ps
`include "dz_settings.svh"

module dzTop (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [1:0]           addr,
   input  logic                 wrStb,
   input  logic [15:0]          wrData,
   input  logic                 rdStb,
   input  logic [`DZ_LINES-1:0] rxLine,
   output logic [15:0]          rdData
);

   // Register block controls
   logic                      mse;
   logic                      sae;
   logic                      clr;
   logic                      rbufRead;
   logic [`DZ_LINES-1:0]      lineRxOn;
   logic [`DZ_LINES-1:0]      lineParEn;
   logic [`DZ_LINES-1:0]      lineParOdd;

   // Silo status
   logic                      rdone;
   logic                      siloAlarm;
   dzPkg::dzWord              rbufWord;
   logic [`DZ_LINES-1:0]      lineClr;

   // Receiver outputs
   logic [`DZ_LINES-1:0]      rxFull;
   logic [`DZ_LINES-1:0][7:0] rxData;
   logic [`DZ_LINES-1:0]      rxFrme;
   logic [`DZ_LINES-1:0]      rxPare;

   // Shared receive bus
   logic [2:0]                scan;
   logic                      busFull;
   logic [7:0]                busData;
   logic                      busFrme;
   logic                      busPare;

   dzRegs uRegs (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .wrStb     (wrStb),
      .wrData    (wrData),
      .rdStb     (rdStb),
      .rdone     (rdone),
      .siloAlarm (siloAlarm),
      .rbufWord  (rbufWord),
      .rdData    (rdData),
      .mse       (mse),
      .sae       (sae),
      .clr       (clr),
      .rbufRead  (rbufRead),
      .lineRxOn  (lineRxOn),
      .lineParEn (lineParEn),
      .lineParOdd(lineParOdd)
   );

   // One receiver per line
   for (genvar i = 0; i < `DZ_LINES; i++)
   begin : genRx
      dzUartRx uRx (
         .clk      (clk),
         .rst      (rst),
         .rxOn     (lineRxOn[i]),
         .parEn    (lineParEn[i]),
         .parOdd   (lineParOdd[i]),
         .serialIn (rxLine[i]),
         .rxClr    (lineClr[i]),
         .full     (rxFull[i]),
         .data     (rxData[i]),
         .frameErr (rxFrme[i]),
         .parityErr(rxPare[i])
      );
   end

   dzScanner uScanner (
      .clk    (clk),
      .rst    (rst),
      .full   (rxFull),
      .data   (rxData),
      .frme   (rxFrme),
      .pare   (rxPare),
      .scan   (scan),
      .busFull(busFull),
      .busData(busData),
      .busFrme(busFrme),
      .busPare(busPare)
   );

   dzRbuf uRbuf (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .mse      (mse),
      .sae      (sae),
      .scan     (scan),
      .busFull  (busFull),
      .busData  (busData),
      .busFrme  (busFrme),
      .busPare  (busPare),
      .rbufRead (rbufRead),
      .lineClr  (lineClr),
      .rdone    (rdone),
      .siloAlarm(siloAlarm),
      .rbufWord (rbufWord)
   );

endmodule

// ==== src/dzUartRx.sv ====
`timescale 1ns/1ps
`include "dz_settings.svh"

module dzUartRx (
   input  logic       clk,
   input  logic       rst,
   input  logic       rxOn,
   input  logic       parEn,
   input  logic       parOdd,
   input  logic       serialIn,
   input  logic       rxClr,
   output logic       full,
   output logic [7:0] data,
   output logic       frameErr,
   output logic       parityErr
);

   localparam int CntW = $clog2(`DZ_BIT_CYCLES);
   localparam logic [CntW-1:0] HalfBit = CntW'(`DZ_BIT_CYCLES / 2 - 1);
   localparam logic [CntW-1:0] FullBit = CntW'(`DZ_BIT_CYCLES - 1);

   // FSM state codes
   localparam logic [2:0] StIdle   = 3'd0;
   localparam logic [2:0] StStart  = 3'd1;
   localparam logic [2:0] StData   = 3'd2;
   localparam logic [2:0] StParity = 3'd3;
   localparam logic [2:0] StStop   = 3'd4;

   logic [2:0]      state;
   logic [CntW-1:0] cnt;
   logic [2:0]      bitIdx;
   logic [7:0]      shiftReg;
   logic            parBit;
   logic            rxPrev;
   logic            startEdge;
   logic            sampleNow;
   logic            stopDone;

   // Falling edge on an idle, enabled line
   assign startEdge = (state == StIdle) & rxOn & rxPrev & ~serialIn;

   // Half a bit into the start bit, then one full bit per sample
   assign sampleNow = (state == StStart) ? (cnt == HalfBit) : (cnt == FullBit);

   // Middle of the stop bit
   assign stopDone = (state == StStop) & sampleNow;

   //////////////////////////////
   // Bit timing FSM
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= StIdle;
         cnt    <= '0;
         bitIdx <= '0;
         rxPrev <= 1'b1;
      end
      else
      begin
         rxPrev <= serialIn;
         case (state)
            StIdle:
            begin
               cnt <= '0;
               if (startEdge)
                  state <= StStart;
            end
            StStart:
            begin
               if (sampleNow)
               begin
                  cnt    <= '0;
                  bitIdx <= '0;
                  // Glitch shorter than half a bit is dropped
                  state  <= serialIn ? StIdle : StData;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            StData:
            begin
               if (sampleNow)
               begin
                  cnt <= '0;
                  if (bitIdx == 3'd7)
                     state <= parEn ? StParity : StStop;
                  else
                     bitIdx <= bitIdx + 1'b1;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            StParity:
            begin
               if (sampleNow)
               begin
                  cnt   <= '0;
                  state <= StStop;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            StStop:
            begin
               if (sampleNow)
               begin
                  cnt   <= '0;
                  state <= StIdle;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            default:
               state <= StIdle;
         endcase
      end
   end

   //////////////////////////////
   // Character assembly
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      // LSB arrives first
      if ((state == StData) && sampleNow)
         shiftReg <= {serialIn, shiftReg[7:1]};
      if ((state == StParity) && sampleNow)
         parBit <= serialIn;
      if (stopDone)
      begin
         data      <= shiftReg;
         frameErr  <= ~serialIn;
         // Odd parity wants an odd count of ones over data and parity bit
         parityErr <= parEn & ((^shiftReg ^ parBit) != parOdd);
      end
   end

   // New character wins over a clear in the same cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         full <= 1'b0;
      else if (stopDone)
         full <= 1'b1;
      else if (rxClr)
         full <= 1'b0;
   end

   // Silo only clears a line whose flag it saw high
   idleClrCheck: assert property (@(posedge clk) disable iff (rst)
      ((state == StIdle) && !full) |-> !rxClr);

endmodule

// ==== src/dz_settings.svh ====
`ifndef DZ_SETTINGS_SVH
`define DZ_SETTINGS_SVH

// Serial bit time in clock cycles, same for every line
`define DZ_BIT_CYCLES 16

// Silo depth
// One slot stays unused so 64 characters fit before overrun
`define DZ_SILO_SIZE 65

// Stored characters that raise the silo alarm
`define DZ_ALARM_COUNT 16

// Line count, tied to the 3-bit line field
`define DZ_LINES 8

// Host register offsets on the 2-bit address
`define DZ_ADDR_CSR 2'd0
`define DZ_ADDR_RBUF 2'd2

`endif

// ==== tb.f ====
+incdir+src
src/dzPkg.sv
src/dzUartRx.sv
src/dzScanner.sv
src/dzRbuf.sv
src/dzRegs.sv
src/dzTop.sv
testbench/dzTb.sv

// ==== testbench/dzTb.sv ====
`timescale 1ns/1ps
`include "dz_settings.svh"

module dzTb;

   localparam int BitCycles = `DZ_BIT_CYCLES;
   localparam int PollLimit = 400;

   logic                 clk;
   logic                 rst;
   logic [1:0]           addr;
   logic                 wrStb;
   logic [15:0]          wrData;
   logic                 rdStb;
   logic [`DZ_LINES-1:0] rxLine;
   logic [15:0]          rdData;

   // Expected silo contents, oldest first
   dzPkg::siloEntry model [$];

   int errors;
   int checks;

   dzTop dut0 (
      .clk   (clk),
      .rst   (rst),
      .addr  (addr),
      .wrStb (wrStb),
      .wrData(wrData),
      .rdStb (rdStb),
      .rxLine(rxLine),
      .rdData(rdData)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic checkRbuf(input string name, input dzPkg::rbufFields exp,
                            input dzPkg::rbufFields act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // Ends a run that cannot continue
   task automatic abortRun(input string why);
      errors++;
      $display("%s", why);
      $display("checks %0d, errors %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
   endtask

   //////////////////////////////
   // Host bus
   //////////////////////////////

   task automatic waitCycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // One cycle write strobe
   task automatic writeReg(input logic [1:0] a, input logic [15:0] d);
      @(posedge clk);
      addr   <= a;
      wrData <= d;
      wrStb  <= 1'b1;
      @(posedge clk);
      wrStb  <= 1'b0;
   endtask

   // Sampled mid cycle while rdStb is held
   task automatic readReg(input logic [1:0] a, output logic [15:0] d);
      @(posedge clk);
      addr  <= a;
      rdStb <= 1'b1;
      @(negedge clk);
      d = rdData;
      @(posedge clk);
      rdStb <= 1'b0;
   endtask

   function automatic logic [15:0] csrWord(input logic clr, input logic mse,
                                           input logic sae);
      logic [15:0] w;
      w     = '0;
      w[4]  = clr;
      w[5]  = mse;
      w[12] = sae;
      return w;
   endfunction

   // LPR load for one line, 8-bit characters
   task automatic setLine(input int line, input logic rxOn, input logic parEn,
                          input logic parOdd);
      dzPkg::dzWord w;
      w             = '0;
      w.lpr.line    = 3'(line);
      w.lpr.rxOn    = rxOn;
      w.lpr.parEn   = parEn;
      w.lpr.parOdd  = parOdd;
      w.lpr.charLen = 2'b11;
      writeReg(`DZ_ADDR_RBUF, w);
   endtask

   // Polls one CSR bit
   task automatic waitCsrBit(input int bitIdx, input logic value, input string what);
      logic [15:0] w;
      logic        seen;
      seen = 1'b0;
      for (int i = 0; i < PollLimit && !seen; i++)
      begin
         readReg(`DZ_ADDR_CSR, w);
         if (w[bitIdx] === value)
            seen = 1'b1;
      end
      if (!seen)
         abortRun({"timeout waiting for ", what});
   endtask

   //////////////////////////////
   // Serial line model
   //////////////////////////////

   // Start, 8 data bits LSB first, optional parity, stop, then 2 idle bit times
   task automatic sendChar(input int line, input logic [7:0] d, input logic withPar,
                           input logic parBit, input logic stopBit);
      rxLine[line] <= 1'b0;
      waitCycles(BitCycles);
      for (int i = 0; i < 8; i++)
      begin
         rxLine[line] <= d[i];
         waitCycles(BitCycles);
      end
      if (withPar)
      begin
         rxLine[line] <= parBit;
         waitCycles(BitCycles);
      end
      rxLine[line] <= stopBit;
      waitCycles(BitCycles);
      rxLine[line] <= 1'b1;
      waitCycles(2 * BitCycles);
   endtask

   //////////////////////////////
   // Reference silo
   //////////////////////////////

   function automatic dzPkg::siloEntry makeEntry(input int line, input logic [7:0] d,
                                                 input logic frme, input logic pare);
      dzPkg::siloEntry e;
      e      = '0;
      e.line = 3'(line);
      e.data = d;
      e.frme = frme;
      e.pare = pare;
      return e;
   endfunction

   // A full model of 64 entries swaps its newest entry
   function automatic void expectStore(input dzPkg::siloEntry e);
      if (model.size() == `DZ_SILO_SIZE - 1)
      begin
         e.ovre = 1'b1;
         model[model.size() - 1] = e;
      end
      else
         model.push_back(e);
   endfunction

   task automatic sendRandom(input int line);
      logic [7:0] d;
      d = 8'($urandom);
      sendChar(line, d, 1'b0, 1'b0, 1'b1);
      expectStore(makeEntry(line, d, 1'b0, 1'b0));
   endtask

   // Reads every expected entry, then silo must be empty
   task automatic drainSilo(input string name);
      dzPkg::siloEntry e;
      logic [15:0]     w;
      if (model.size() > 0)
         waitCsrBit(7, 1'b1, "rdone to rise");
      while (model.size() > 0)
      begin
         e = model.pop_front();
         readReg(`DZ_ADDR_RBUF, w);
         checkRbuf(name, {1'b1, e}, w);
         waitCycles(4);
      end
      readReg(`DZ_ADDR_CSR, w);
      checkFlag({name, " rdone"}, 1'b0, w[7]);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      int          lineA;
      int          lineB;
      int          pl;
      logic [7:0]  dA;
      logic [7:0]  dB;
      logic [15:0] w;
      dzPkg::siloEntry e;

      void'($urandom(32'h00ef_b14b));
      errors = 0;
      checks = 0;
      rst    <= 1'b1;
      addr   <= '0;
      wrStb  <= 1'b0;
      wrData <= '0;
      rdStb  <= 1'b0;
      rxLine <= '1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // CSR state out of reset
      readReg(`DZ_ADDR_CSR, w);
      checkFlag("reset mse", 1'b0, w[5]);
      checkFlag("reset sae", 1'b0, w[12]);
      checkFlag("reset rdone", 1'b0, w[7]);
      checkFlag("reset alarm", 1'b0, w[13]);

      // All lines on, no parity, scanning enabled
      for (int i = 0; i < `DZ_LINES; i++)
         setLine(i, 1'b1, 1'b0, 1'b0);
      writeReg(`DZ_ADDR_CSR, csrWord(1'b0, 1'b1, 1'b0));
      readReg(`DZ_ADDR_CSR, w);
      checkFlag("csr mse", 1'b1, w[5]);

      // Pairs on two lines with the second start 2 bit times later
      for (int k = 0; k < 4; k++)
      begin
         lineA = $urandom_range(7, 0);
         lineB = (lineA + 1 + $urandom_range(6, 0)) % `DZ_LINES;
         dA    = 8'($urandom);
         dB    = 8'($urandom);
         fork
            sendChar(lineA, dA, 1'b0, 1'b0, 1'b1);
            begin
               waitCycles(2 * BitCycles);
               sendChar(lineB, dB, 1'b0, 1'b0, 1'b1);
            end
         join
         expectStore(makeEntry(lineA, dA, 1'b0, 1'b0));
         expectStore(makeEntry(lineB, dB, 1'b0, 1'b0));
      end
      drainSilo("random");

      // Odd parity on one line
      pl = $urandom_range(7, 0);
      setLine(pl, 1'b1, 1'b1, 1'b1);
      dA = 8'($urandom);
      sendChar(pl, dA, 1'b1, ^dA, 1'b1);
      expectStore(makeEntry(pl, dA, 1'b0, 1'b1));
      dA = 8'($urandom);
      sendChar(pl, dA, 1'b1, ~^dA, 1'b1);
      expectStore(makeEntry(pl, dA, 1'b0, 1'b0));
      // Stop bit held low
      dA = 8'($urandom);
      sendChar(pl, dA, 1'b1, ~^dA, 1'b0);
      expectStore(makeEntry(pl, dA, 1'b1, 1'b0));
      drainSilo("parity");
      setLine(pl, 1'b1, 1'b0, 1'b0);

      // Alarm at 16 stores
      writeReg(`DZ_ADDR_CSR, csrWord(1'b1, 1'b1, 1'b1));
      waitCycles(2);
      repeat (15)
         sendRandom($urandom_range(7, 0));
      readReg(`DZ_ADDR_CSR, w);
      checkFlag("csr sae", 1'b1, w[12]);
      checkFlag("alarm after 15", 1'b0, w[13]);
      sendRandom($urandom_range(7, 0));
      waitCsrBit(13, 1'b1, "silo alarm to rise");
      e = model.pop_front();
      readReg(`DZ_ADDR_RBUF, w);
      checkRbuf("alarm", {1'b1, e}, w);
      waitCycles(4);
      readReg(`DZ_ADDR_CSR, w);
      checkFlag("alarm after read", 1'b0, w[13]);
      drainSilo("alarm");

      // 65 characters, no reads
      writeReg(`DZ_ADDR_CSR, csrWord(1'b1, 1'b1, 1'b0));
      waitCycles(2);
      repeat (65)
         sendRandom($urandom_range(7, 0));
      drainSilo("overrun");

      // Clear drops stored characters
      sendRandom($urandom_range(7, 0));
      sendRandom($urandom_range(7, 0));
      waitCsrBit(7, 1'b1, "rdone before clear");
      writeReg(`DZ_ADDR_CSR, csrWord(1'b1, 1'b1, 1'b0));
      model.delete();
      waitCycles(2);
      readReg(`DZ_ADDR_CSR, w);
      checkFlag("clear rdone", 1'b0, w[7]);
      checkFlag("clear pulse", 1'b0, w[4]);

      // Scan off, then one line disabled
      writeReg(`DZ_ADDR_CSR, csrWord(1'b0, 1'b0, 1'b0));
      lineA = $urandom_range(7, 0);
      lineB = (lineA + 1 + $urandom_range(6, 0)) % `DZ_LINES;
      dA    = 8'($urandom);
      dB    = 8'($urandom);
      sendChar(lineA, dA, 1'b0, 1'b0, 1'b1);
      setLine(lineB, 1'b0, 1'b0, 1'b0);
      sendChar(lineB, dB, 1'b0, 1'b0, 1'b1);
      readReg(`DZ_ADDR_CSR, w);
      checkFlag("mse low rdone", 1'b0, w[7]);
      // Held character on the enabled line goes in once scanning resumes
      writeReg(`DZ_ADDR_CSR, csrWord(1'b0, 1'b1, 1'b0));
      expectStore(makeEntry(lineA, dA, 1'b0, 1'b0));
      drainSilo("enables");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule
